// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_dts_align
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Test failed
SRCS      := $(wildcard design/*.sv design/*.svh test/*.sv test/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/dts_align_cfg.svh
`ifndef DTS_ALIGN_CFG_SVH
`define DTS_ALIGN_CFG_SVH

// Lanes aligned against lane 0
`define DTS_NUM_LANES 4

// Payload bits in one beat
`define DTS_BEAT_W 128

// FIFO words per lane at a mux factor of 1
`define DTS_FIFO_DEPTH 32

// Largest sync skew searched, in beats, kept below half the FIFO depth
`define DTS_SKEW_WIN 12

// clk_out cycles to wait after a slip before measuring again
`define DTS_SETTLE_CYC 16

`endif

// File: design/dts_align_ctrl.sv
`timescale 1ns/1ps
`include "dts_align_cfg.svh"

module dts_align_ctrl
  import dts_stream_pkg::*;
  import dts_ctrl_pkg::*;
(
  input  logic                      clk_out,
  input  logic                      rst_wr_clkR,
  input  dts_beat_t                 lane_dout [`DTS_NUM_LANES],
  output logic [`DTS_NUM_LANES-1:0] advance,
  output logic [`DTS_NUM_LANES-1:0] delay,
  output logic [7:0]                slip_cnt [`DTS_NUM_LANES],
  output slip_op_e                  last_op [`DTS_NUM_LANES],
  output logic                      aligned
);

  localparam int N        = `DTS_NUM_LANES;
  localparam int LANE_W   = (N > 1) ? $clog2(N) : 1;
  localparam int AGE_MAX  = `DTS_SKEW_WIN + 1;
  localparam int AGE_W    = $clog2(AGE_MAX + 1);
  // Offsetters run at mux factor 1, plus read and output latency
  localparam int WAIT_CYC = `DTS_FIFO_DEPTH / 2 + 4;
  localparam int HOLD_CYC = 4;
  localparam int TMR_W    = $clog2(WAIT_CYC + `DTS_SETTLE_CYC + `DTS_SKEW_WIN);

  align_state_e      state;
  logic [TMR_W-1:0]  tmr;
  logic              armed;
  logic [N-1:0]      sync_now;
  logic [AGE_W-1:0]  age [N];
  logic [N-1:0]      found, early, late;
  logic [N-1:0]      cap_found, cap_early;
  logic [LANE_W-1:0] slip_lane;
  slip_op_e          slip_op;
  logic              pick_valid, pick_early;
  logic [LANE_W-1:0] pick_lane;

  // Cycles since each lane last showed sync, saturating past the window
  always_ff @(posedge clk_out) begin
    for (int i = 0; i < N; i++) begin
      if (rst_wr_clkR) begin
        age[i] <= AGE_W'(AGE_MAX);
      end else if (sync_now[i]) begin
        age[i] <= AGE_W'(1);
      end else if (age[i] != AGE_W'(AGE_MAX)) begin
        age[i] <= age[i] + 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N; i++) begin
      sync_now[i]  = lane_dout[i].sync;
      cap_early[i] = !sync_now[i] && (age[i] <= AGE_W'(`DTS_SKEW_WIN));
      cap_found[i] = sync_now[i] || cap_early[i];
    end
  end

  // Lowest skewed lane gets the next slip, lane 0 is never chosen
  always_comb begin
    pick_valid = 1'b0;
    pick_lane  = '0;
    pick_early = 1'b0;
    for (int i = N - 1; i >= 1; i--) begin
      if (early[i] || late[i]) begin
        pick_valid = 1'b1;
        pick_lane  = LANE_W'(i);
        pick_early = early[i];
      end
    end
  end

  ////////////////////
  // Alignment FSM
  always_ff @(posedge clk_out) begin
    if (rst_wr_clkR) begin
      state     <= WAIT_FILL;
      tmr       <= TMR_W'(WAIT_CYC - 1);
      armed     <= 1'b0;
      found     <= '0;
      early     <= '0;
      late      <= '0;
      slip_lane <= '0;
      slip_op   <= SLIP_NONE;
      for (int i = 0; i < N; i++) begin
        slip_cnt[i] <= '0;
        last_op[i]  <= SLIP_NONE;
      end
    end else begin
      case (state)
        WAIT_FILL: begin
          if (tmr == '0) begin
            state <= FIND_REF;
          end else begin
            tmr <= tmr - 1'b1;
          end
        end
        FIND_REF, MEASURE: begin
          if (!armed && sync_now[0]) begin
            // Reference sync seen, lanes already past it are early
            state <= MEASURE;
            armed <= 1'b1;
            found <= cap_found;
            early <= cap_early;
            late  <= '0;
            tmr   <= TMR_W'(`DTS_SKEW_WIN);
          end else if (armed && tmr != '0) begin
            tmr <= tmr - 1'b1;
            for (int i = 0; i < N; i++) begin
              if (!found[i] && sync_now[i]) begin
                found[i] <= 1'b1;
                late[i]  <= 1'b1;
              end
            end
          end else if (armed) begin
            armed <= 1'b0;
            if ((&found) && !(|(early | late))) begin
              state <= LOCKED;
            end else if (pick_valid) begin
              state                <= SLIP;
              tmr                  <= TMR_W'(HOLD_CYC - 1);
              slip_lane            <= pick_lane;
              slip_op              <= pick_early ? SLIP_DELAY : SLIP_ADVANCE;
              slip_cnt[pick_lane]  <= slip_cnt[pick_lane] + 8'd1;
              last_op[pick_lane]   <= pick_early ? SLIP_DELAY : SLIP_ADVANCE;
            end
          end
        end
        SLIP: begin
          if (tmr == '0) begin
            state <= SETTLE;
            tmr   <= TMR_W'(`DTS_SETTLE_CYC - 1);
          end else begin
            tmr <= tmr - 1'b1;
          end
        end
        SETTLE: begin
          if (tmr == '0) begin
            state <= MEASURE;
          end else begin
            tmr <= tmr - 1'b1;
          end
        end
        LOCKED: begin
          // Any frame where the lanes disagree on sync means skew is back
          if ((|sync_now) && !(&sync_now)) begin
            state <= MEASURE;
          end
        end
        default: state <= WAIT_FILL;
      endcase
    end
  end

  always_comb begin
    for (int i = 0; i < N; i++) begin
      advance[i] = (state == SLIP) && (slip_lane == LANE_W'(i)) && (slip_op == SLIP_ADVANCE);
      delay[i]   = (state == SLIP) && (slip_lane == LANE_W'(i)) && (slip_op == SLIP_DELAY);
    end
  end

  assign aligned = (state == LOCKED);

  // A request level lasts exactly the hold time so clk_in can sample it
  for (genvar g = 0; g < N; g++) begin : g_chk
    a_slip_hold: assert property (@(posedge clk_out) disable iff (rst_wr_clkR)
      $rose(advance[g] | delay[g]) |->
        (advance[g] | delay[g]) [*HOLD_CYC] ##1 !(advance[g] | delay[g]));
  end

endmodule

// File: design/dts_align_top.sv
`timescale 1ns/1ps
`include "dts_align_cfg.svh"

module dts_align_top
  import dts_stream_pkg::*;
  import dts_ctrl_pkg::*;
(
  input  logic         clk_in,
  input  logic         clk_out,
  input  logic         rst_wr_clkR,
  input  dts_beat_t    din [`DTS_NUM_LANES],
  output dts_beat_t    dout [`DTS_NUM_LANES],
  output lane_status_t lane_status [`DTS_NUM_LANES],
  output logic         aligned
);

  logic [`DTS_NUM_LANES-1:0] advance;
  logic [`DTS_NUM_LANES-1:0] delay;
  logic [`DTS_NUM_LANES-1:0] almost_full;
  logic [`DTS_NUM_LANES-1:0] almost_empty;
  logic [`DTS_NUM_LANES-1:0] overflow;
  logic [`DTS_NUM_LANES-1:0] underflow;
  logic [7:0]                slip_cnt [`DTS_NUM_LANES];
  slip_op_e                  last_op [`DTS_NUM_LANES];

  ////////////////////
  // Lanes
  for (genvar i = 0; i < `DTS_NUM_LANES; i++) begin : g_lane
    dts_offsetter #(
      .MUX_FACTOR_BITS (0)
    ) i_offsetter (
      .clk_in       (clk_in),
      .clk_out      (clk_out),
      .rst_wr_clkR  (rst_wr_clkR),
      .din          (din[i]),
      .advance      (advance[i]),
      .delay        (delay[i]),
      .dout         (dout[i]),
      .almost_full  (almost_full[i]),
      .almost_empty (almost_empty[i]),
      .overflow     (overflow[i]),
      .underflow    (underflow[i])
    );

    assign lane_status[i] = '{
      slip_cnt:     slip_cnt[i],
      last_op:      last_op[i],
      almost_full:  almost_full[i],
      almost_empty: almost_empty[i],
      overflow:     overflow[i],
      underflow:    underflow[i]
    };
  end

  // Controller watches the aligned outputs, lane 0 is the reference
  dts_align_ctrl i_ctrl (
    .clk_out     (clk_out),
    .rst_wr_clkR (rst_wr_clkR),
    .lane_dout   (dout),
    .advance     (advance),
    .delay       (delay),
    .slip_cnt    (slip_cnt),
    .last_op     (last_op),
    .aligned     (aligned)
  );

endmodule

// File: design/dts_ctrl_pkg.sv
package dts_ctrl_pkg;

  // Alignment controller states
  typedef enum logic [2:0] {
    WAIT_FILL = 3'd0,
    FIND_REF  = 3'd1,
    MEASURE   = 3'd2,
    SLIP      = 3'd3,
    SETTLE    = 3'd4,
    LOCKED    = 3'd5
  } align_state_e;

  // Slip request issued to one lane
  typedef enum logic [1:0] {
    SLIP_NONE    = 2'd0,
    SLIP_ADVANCE = 2'd1,
    SLIP_DELAY   = 2'd2
  } slip_op_e;

  // Per lane status, assembled at the top level
  typedef struct packed {
    logic [7:0] slip_cnt;
    slip_op_e   last_op;
    logic       almost_full;
    logic       almost_empty;
    logic       overflow;
    logic       underflow;
  } lane_status_t;

endpackage

// File: design/dts_offset_fifo.sv
`timescale 1ns/1ps

module dts_offset_fifo
  import dts_stream_pkg::*;
#(
  parameter int DEPTH      = 32,
  parameter int MUX_FACTOR = 1
) (
  input  logic           clk_in,
  input  logic           clk_out,
  input  logic           rst_wr_clkR,
  input  logic           wr_en,
  input  dts_fifo_word_t din [MUX_FACTOR],
  input  logic           rd_en,
  output dts_fifo_word_t dout,
  output logic           almost_full,
  output logic           almost_empty,
  output logic           overflow,
  output logic           underflow
);

  localparam int AW     = $clog2(DEPTH);
  localparam int MFB    = $clog2(MUX_FACTOR);
  localparam int PW     = AW + 1;
  localparam int BPW    = PW - MFB;
  localparam int AF_LVL = DEPTH - DEPTH / 4;
  localparam int AE_LVL = DEPTH / 4;

  function automatic logic [PW-1:0] bin2gray(logic [PW-1:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [PW-1:0] gray2bin(logic [PW-1:0] g);
    logic [PW-1:0] b;
    b[PW-1] = g[PW-1];
    for (int i = PW - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  dts_fifo_word_t mem [DEPTH];

  ////////////////////
  // Reset crossing
  logic [1:0] wr_rst_sync;
  logic [1:0] rd_rst_hold;
  logic       wr_rst;
  logic       rd_rst;

  always_ff @(posedge clk_in) begin
    wr_rst_sync <= {wr_rst_sync[0], rst_wr_clkR};
  end

  // Read side stays in reset two cycles past the input
  always_ff @(posedge clk_out) begin
    rd_rst_hold <= {rd_rst_hold[0], rst_wr_clkR};
  end

  assign wr_rst = wr_rst_sync[1];
  assign rd_rst = rst_wr_clkR | rd_rst_hold[0] | rd_rst_hold[1];

  ////////////////////
  // Write side, pointer counts whole beats so its Gray code moves one bit
  logic [BPW-1:0] wr_bptr;
  logic [BPW-1:0] wr_gray;
  logic [PW-1:0]  wr_wptr;
  logic [PW-1:0]  rd_gray_s1;
  logic [PW-1:0]  rd_gray_s2;
  logic [PW-1:0]  wr_level;
  logic           wr_full;

  assign wr_wptr  = PW'(wr_bptr) << MFB;
  assign wr_level = wr_wptr - gray2bin(rd_gray_s2);
  assign wr_full  = wr_level > PW'(DEPTH - MUX_FACTOR);

  always_ff @(posedge clk_in) begin
    if (wr_rst) begin
      wr_bptr    <= '0;
      wr_gray    <= '0;
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
      overflow   <= 1'b0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
      if (wr_en && wr_full) begin
        overflow <= 1'b1;
      end else if (wr_en) begin
        wr_bptr <= wr_bptr + 1'b1;
        wr_gray <= BPW'(bin2gray(PW'(wr_bptr + 1'b1)));
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (wr_en && !wr_full && !wr_rst) begin
      for (int k = 0; k < MUX_FACTOR; k++) begin
        mem[wr_wptr[AW-1:0] + AW'(k)] <= din[k];
      end
    end
  end

  assign almost_full = wr_level >= PW'(AF_LVL);

  ////////////////////
  // Read side
  logic [PW-1:0]  rd_ptr;
  logic [PW-1:0]  rd_gray;
  logic [BPW-1:0] wr_gray_s1;
  logic [BPW-1:0] wr_gray_s2;
  logic [PW-1:0]  rd_wptr;
  logic [PW-1:0]  rd_level;
  logic           rd_empty;

  assign rd_wptr  = PW'(BPW'(gray2bin(PW'(wr_gray_s2)))) << MFB;
  assign rd_level = rd_wptr - rd_ptr;
  assign rd_empty = rd_level == '0;

  // dout is cleared so a blocked lane reads as an all-zero beat
  always_ff @(posedge clk_out) begin
    if (rd_rst) begin
      rd_ptr     <= '0;
      rd_gray    <= '0;
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
      underflow  <= 1'b0;
      dout       <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
      if (rd_en && rd_empty) begin
        underflow <= 1'b1;
      end else if (rd_en) begin
        dout    <= mem[rd_ptr[AW-1:0]];
        rd_ptr  <= rd_ptr + 1'b1;
        rd_gray <= bin2gray(rd_ptr + 1'b1);
      end
    end
  end

  assign almost_empty = rd_level <= PW'(AE_LVL);

  // Read side view of the crossed write pointer must stay within one FIFO
  a_level_in_range: assert property (@(posedge clk_out) disable iff (rd_rst)
    rd_level <= PW'(DEPTH));

endmodule

// File: design/dts_offsetter.sv
`timescale 1ns/1ps
`include "dts_align_cfg.svh"

module dts_offsetter
  import dts_stream_pkg::*;
#(
  parameter int MUX_FACTOR_BITS = 0
) (
  input  logic      clk_in,
  input  logic      clk_out,
  input  logic      rst_wr_clkR,
  input  dts_beat_t din,
  input  logic      advance,
  input  logic      delay,
  output dts_beat_t dout,
  output logic      almost_full,
  output logic      almost_empty,
  output logic      overflow,
  output logic      underflow
);

  localparam int MUX_FACTOR     = 1 << MUX_FACTOR_BITS;
  localparam int FIFO_DEPTH     = `DTS_FIFO_DEPTH * MUX_FACTOR;
  localparam int MID_FIFO_DEPTH = FIFO_DEPTH / 2;
  localparam int CTR_W          = $clog2(MID_FIFO_DEPTH + 1);

  ////////////////////
  // Advance drops one write
  logic [2:0] advance_sr;
  logic       advance_strobe;
  logic       fifo_wr_en;

  // Two sync flops, the third keeps the previous level
  always_ff @(posedge clk_in) begin
    advance_sr <= {advance_sr[1:0], advance};
  end

  assign advance_strobe = advance_sr[1] & ~advance_sr[2];
  assign fifo_wr_en     = ~advance_strobe;

  ////////////////////
  // Delay withholds one beat of reads
  logic delay_q;
  logic delay_strobe;
  logic rd_hold;

  always_ff @(posedge clk_out) begin
    if (rst_wr_clkR) begin
      delay_q <= 1'b0;
    end else begin
      delay_q <= delay;
    end
  end

  assign delay_strobe = delay & ~delay_q;

  generate
    if (MUX_FACTOR > 1) begin : g_stretch
      // A beat spans MUX_FACTOR words, so hold reads that many cycles
      logic [MUX_FACTOR-2:0] delay_sr;

      always_ff @(posedge clk_out) begin
        if (rst_wr_clkR) begin
          delay_sr <= '0;
        end else begin
          delay_sr <= (delay_sr << 1) | (MUX_FACTOR - 1)'(delay_strobe);
        end
      end

      assign rd_hold = delay_strobe | (|delay_sr);
    end else begin : g_no_stretch
      assign rd_hold = delay_strobe;
    end
  endgenerate

  ////////////////////
  // Read hold-off so the FIFO settles half full
  logic             rd_block;
  logic [CTR_W-1:0] block_ctr;
  logic             fifo_rd_en;

  always_ff @(posedge clk_out) begin
    if (rst_wr_clkR) begin
      rd_block  <= 1'b1;
      block_ctr <= CTR_W'(MID_FIFO_DEPTH - 1);
    end else if (rd_block) begin
      if (block_ctr == '0) begin
        rd_block <= 1'b0;
      end else begin
        block_ctr <= block_ctr - 1'b1;
      end
    end
  end

  assign fifo_rd_en = ~rd_hold & ~rd_block;

  // Split each beat into MUX_FACTOR words, lowest slice first
  dts_fifo_word_t fifo_din [MUX_FACTOR];
  dts_fifo_word_t fifo_dout;

  for (genvar k = 0; k < MUX_FACTOR; k++) begin : g_split
    assign fifo_din[k] = beat_slice(din, k, MUX_FACTOR_BITS);
  end

  dts_offset_fifo #(
    .DEPTH      (FIFO_DEPTH),
    .MUX_FACTOR (MUX_FACTOR)
  ) i_fifo (
    .clk_in       (clk_in),
    .clk_out      (clk_out),
    .rst_wr_clkR  (rst_wr_clkR),
    .wr_en        (fifo_wr_en),
    .din          (fifo_din),
    .rd_en        (fifo_rd_en),
    .dout         (fifo_dout),
    .almost_full  (almost_full),
    .almost_empty (almost_empty),
    .overflow     (overflow),
    .underflow    (underflow)
  );

  assign dout = word_to_beat(fifo_dout);

  // The controller must not slip a lane before its reads have started
  a_no_delay_blocked: assert property (@(posedge clk_out) disable iff (rst_wr_clkR)
    delay_strobe |-> !rd_block);

endmodule

// File: design/dts_stream_pkg.sv
`include "dts_align_cfg.svh"

package dts_stream_pkg;

  // One beat as it leaves the deformatter
  typedef struct packed {
    logic [`DTS_BEAT_W-1:0] data;
    logic                   one_sec;
    logic                   ten_sec;
    logic                   index;
    logic                   sync;
  } dts_beat_t;

  // FIFO word, sized for the widest slice; narrower slices sit in the low bits
  typedef struct packed {
    logic [3:0]             markers;
    logic [`DTS_BEAT_W-1:0] data;
  } dts_fifo_word_t;

  // Slice idx of a beat, markers repeated in every slice
  function automatic dts_fifo_word_t beat_slice(dts_beat_t beat, int unsigned idx,
                                                int unsigned mfb);
    int unsigned            slice_w;
    logic [`DTS_BEAT_W-1:0] mask;
    dts_fifo_word_t         word;
    slice_w      = `DTS_BEAT_W >> mfb;
    mask         = {`DTS_BEAT_W{1'b1}} >> (`DTS_BEAT_W - slice_w);
    word.markers = {beat.one_sec, beat.ten_sec, beat.index, beat.sync};
    word.data    = (beat.data >> (idx * slice_w)) & mask;
    return word;
  endfunction

  function automatic dts_beat_t word_to_beat(dts_fifo_word_t word);
    dts_beat_t beat;
    beat.data = word.data;
    {beat.one_sec, beat.ten_sec, beat.index, beat.sync} = word.markers;
    return beat;
  endfunction

endpackage

// File: tb.f
+incdir+design
+incdir+test
design/dts_stream_pkg.sv
design/dts_ctrl_pkg.sv
design/dts_offset_fifo.sv
design/dts_offsetter.sv
design/dts_align_ctrl.sv
design/dts_align_top.sv
test/tb_dts_align.sv

// File: test/dts_align_tb_tasks.svh
`ifndef DTS_ALIGN_TB_TASKS_SVH
`define DTS_ALIGN_TB_TASKS_SVH

  // Source beats in the order lane 0 receives them
  dts_beat_t src_q [$];

  function automatic void push_source(dts_beat_t beat);
    src_q.push_back(beat);
  endfunction

  task automatic pop_expected(output dts_beat_t beat, output logic ok);
    ok   = src_q.size() > 0;
    beat = '0;
    if (ok) begin
      beat = src_q.pop_front();
    end
  endtask

  // Beats written before the first sync never reach the compare
  function automatic void drop_until_sync();
    while (src_q.size() > 0 && !src_q[0].sync) begin
      src_q.delete(0);
    end
  endfunction

  function automatic lane_status_t expect_status(int cnt, slip_op_e op);
    lane_status_t st;
    st          = '0;
    st.slip_cnt = 8'(cnt);
    st.last_op  = op;
    return st;
  endfunction

  ////////////////////
  // Compares

  task automatic check_beat(input int lane, input dts_beat_t got, input dts_beat_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error lane%0d dout: got %h, expected %h", lane, got, exp);
    end
  endtask

  task automatic check_status(input int lane, input lane_status_t got,
                              input lane_status_t exp);
    checks++;
    if (got.slip_cnt !== exp.slip_cnt) begin
      errors++;
      $display("error lane%0d slip_cnt: got %h, expected %h", lane, got.slip_cnt,
               exp.slip_cnt);
    end
    if (got.last_op !== exp.last_op) begin
      errors++;
      $display("error lane%0d last_op: got %h, expected %h", lane, got.last_op, exp.last_op);
    end
    if (got.overflow !== exp.overflow) begin
      errors++;
      $display("error lane%0d overflow: got %h, expected %h", lane, got.overflow,
               exp.overflow);
    end
    if (got.underflow !== exp.underflow) begin
      errors++;
      $display("error lane%0d underflow: got %h, expected %h", lane, got.underflow,
               exp.underflow);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

`endif

// File: test/tb_dts_align.sv
`timescale 1ns/1ps
`include "dts_align_cfg.svh"

module tb_dts_align
  import dts_stream_pkg::*;
  import dts_ctrl_pkg::*;
();

  localparam int N         = `DTS_NUM_LANES;
  localparam int FRAME_LEN = 64;
  localparam int HIST      = 16;
  localparam int LEAD_IN   = 8;
  localparam int START_TMO = 300;
  localparam int FALL_TMO  = 300;
  localparam int ALIGN_TMO = 4000;
  localparam int STEADY    = 2000;

  logic         clk_in;
  logic         clk_out;
  logic         rst_wr_clkR;
  dts_beat_t    din [N];
  dts_beat_t    dout [N];
  lane_status_t lane_status [N];
  logic         aligned;

  int          offset [N];
  int          base_cnt [N];
  slip_op_e    base_op [N];
  int          errors;
  int          checks;
  int          tests;
  int          err_mark;
  int          beat_num;
  int          lead_cnt;
  logic        lane0_started;
  logic        equal_on;
  dts_beat_t   hist [HIST];
  int unsigned seed;

  `include "dts_align_tb_tasks.svh"

  dts_align_top i_dut (
    .clk_in      (clk_in),
    .clk_out     (clk_out),
    .rst_wr_clkR (rst_wr_clkR),
    .din         (din),
    .dout        (dout),
    .lane_status (lane_status),
    .aligned     (aligned)
  );

  initial begin
    clk_out = 1'b0;
    forever #2 clk_out = ~clk_out;
  end

  // Same rate as clk_out, fixed phase offset
  initial begin
    clk_in = 1'b0;
    #1.3;
    forever #2 clk_in = ~clk_in;
  end

  // Sync opens each frame, index toggles per frame
  function automatic dts_beat_t make_source_beat(int n);
    dts_beat_t b;
    int        frame;
    frame     = n / FRAME_LEN;
    b.data    = {$urandom, $urandom, $urandom, $urandom};
    b.sync    = (n % FRAME_LEN) == 0;
    b.index   = frame[0];
    b.one_sec = b.sync && (frame % 4 == 0);
    b.ten_sec = b.sync && (frame % 40 == 0);
    return b;
  endfunction

  ////////////////////
  // Source and lane skew
  always @(negedge clk_in) begin
    int src_idx;
    if (rst_wr_clkR || lead_cnt < LEAD_IN) begin
      if (!rst_wr_clkR) begin
        lead_cnt++;
      end
      for (int i = 0; i < N; i++) begin
        din[i] = '0;
      end
    end else begin
      hist[beat_num % HIST] = make_source_beat(beat_num);
      for (int i = 0; i < N; i++) begin
        src_idx = beat_num - offset[i];
        din[i]  = (src_idx >= 0) ? hist[src_idx % HIST] : '0;
      end
      if (beat_num - offset[0] >= 0) begin
        push_source(din[0]);
      end
      beat_num++;
    end
  end

  // Lane 0 against the model, other lanes against the same beat once aligned
  always @(negedge clk_out) begin
    dts_beat_t exp;
    logic      have;
    if (!rst_wr_clkR && !lane0_started && dout[0].sync) begin
      lane0_started = 1'b1;
      drop_until_sync();
    end
    if (lane0_started) begin
      pop_expected(exp, have);
      if (!have) begin
        errors++;
        $display("lane 0 produced a beat that the source never sent");
      end else begin
        check_beat(0, dout[0], exp);
        if (equal_on) begin
          for (int i = 1; i < N; i++) begin
            check_beat(i, dout[i], exp);
          end
        end
      end
    end
  end

  task automatic begin_test();
    err_mark = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_mark) ? "passed" : "errors found");
  endtask

  task automatic wait_aligned(input logic level, input int limit, output logic ok);
    int cyc;
    cyc = 0;
    ok  = 1'b0;
    while (!ok && cyc < limit) begin
      @(negedge clk_out);
      ok = (aligned == level);
      cyc++;
    end
    if (!ok) begin
      errors++;
      $display("aligned did not go %s within %0d cycles", level ? "high" : "low", limit);
    end
  endtask

  task automatic wait_lane0(output logic ok);
    int cyc;
    cyc = 0;
    while (!lane0_started && cyc < START_TMO) begin
      @(posedge clk_out);
      cyc++;
    end
    ok = lane0_started;
    if (!ok) begin
      errors++;
      $display("lane 0 showed no sync within %0d cycles", START_TMO);
    end
  endtask

  task automatic run_tests();
    int   hi_cnt;
    int   backlog;
    logic ok;

    begin_test();
    for (int c = 0; c < 12; c++) begin
      @(negedge clk_out);
      check_flag("aligned", aligned, 1'b0);
      for (int i = 0; i < N; i++) begin
        check_beat(i, dout[i], '0);
        // Read side is still in reset and nearly nothing is written yet
        if (c == 0) begin
          check_flag("almost_full", lane_status[i].almost_full, 1'b0);
          check_flag("almost_empty", lane_status[i].almost_empty, 1'b1);
        end
      end
    end
    for (int i = 0; i < N; i++) begin
      check_status(i, lane_status[i], expect_status(0, SLIP_NONE));
    end
    end_test("reset state");

    begin_test();
    wait_lane0(ok);
    if (ok) begin
      repeat (4 * FRAME_LEN) @(negedge clk_out);
    end
    end_test("lane 0 follows source");
    if (!ok) begin
      return;
    end

    begin_test();
    wait_aligned(1'b1, ALIGN_TMO, ok);
    if (ok) begin
      @(posedge clk_out);
      equal_on = 1'b1;
      repeat (2 * FRAME_LEN) @(negedge clk_out);
    end
    end_test("lanes aligned");
    if (!ok) begin
      return;
    end

    begin_test();
    for (int i = 0; i < N; i++) begin
      check_status(i, lane_status[i], expect_status(base_cnt[i], base_op[i]));
    end
    end_test("slip counts");

    // Backlog stays flat when every written beat is read once
    begin_test();
    hi_cnt = 0;
    @(posedge clk_out);
    backlog = src_q.size();
    repeat (STEADY) begin
      @(negedge clk_out);
      if (aligned) begin
        hi_cnt++;
      end
    end
    @(posedge clk_out);
    check_count("aligned cycles", hi_cnt, STEADY);
    check_count("lane 0 model backlog", src_q.size(), backlog);
    @(negedge clk_out);
    for (int i = 0; i < N; i++) begin
      check_status(i, lane_status[i], expect_status(base_cnt[i], base_op[i]));
    end
    end_test("steady state");

    // Repeating one beat makes lane 2 one beat late
    begin_test();
    @(posedge clk_out);
    equal_on  = 1'b0;
    offset[2] = offset[2] + 1;
    wait_aligned(1'b0, FALL_TMO, ok);
    if (ok) begin
      wait_aligned(1'b1, ALIGN_TMO, ok);
    end
    if (ok) begin
      @(posedge clk_out);
      equal_on = 1'b1;
      repeat (2 * FRAME_LEN) @(negedge clk_out);
      base_cnt[2] = base_cnt[2] + 1;
      base_op[2]  = SLIP_ADVANCE;
      for (int i = 0; i < N; i++) begin
        check_status(i, lane_status[i], expect_status(base_cnt[i], base_op[i]));
      end
    end
    end_test("lane 2 jump");
  endtask

  task automatic finish_run();
    $display("tests %0d checks %0d errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  initial begin
    seed          = $urandom(99);
    rst_wr_clkR   = 1'b1;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    beat_num      = 0;
    lead_cnt      = 0;
    lane0_started = 1'b0;
    equal_on      = 1'b0;
    for (int i = 0; i < N; i++) begin
      din[i]    = '0;
      offset[i] = $urandom_range(7, 0);
    end
    // Later lanes get advanced, earlier ones delayed
    for (int i = 0; i < N; i++) begin
      base_cnt[i] = (offset[i] > offset[0]) ? offset[i] - offset[0] : offset[0] - offset[i];
      if (offset[i] > offset[0]) begin
        base_op[i] = SLIP_ADVANCE;
      end else if (offset[i] < offset[0]) begin
        base_op[i] = SLIP_DELAY;
      end else begin
        base_op[i] = SLIP_NONE;
      end
      $display("lane %0d offset %0d", i, offset[i]);
    end
    repeat (2) @(negedge clk_out);
    rst_wr_clkR = 1'b0;
    run_tests();
    finish_run();
  end

endmodule
